// ==== hw/clkPkg.sv ====
// EBOX clock control types and codes

package clkPkg;

  typedef logic [2:0] diagSelT;
  typedef logic [3:0] diagDataT;
  // EBOX tick every rate + 1 CLK cycles
  typedef logic [1:0] rateT;
  typedef logic [7:0] burstCountT;
  // Bit 2 DRAM, bit 1 CRAM, bit 0 FM
  typedef logic [2:0] parErrT;
  typedef logic [5:0] readWordT;

  // Control codes 3 and 5 fall back to stop
  typedef enum logic [2:0] {
    CTL_STOP      = 3'd0,
    CTL_START     = 3'd1,
    CTL_STEP      = 3'd2,
    CTL_BURST     = 3'd4,
    CTL_SET_RESET = 3'd6,
    CTL_CLR_RESET = 3'd7
  } ctlFuncE;

  // Load codes 0, 1 and 5 do nothing
  typedef enum logic [2:0] {
    LD_COUNT_LO  = 3'd2,
    LD_COUNT_HI  = 3'd3,
    LD_RATE      = 3'd4,
    LD_CHECK_EN  = 3'd6,
    LD_ERR_STOP  = 3'd7
  } ldFuncE;

  // Readback selects
  localparam diagSelT RD_STATUS   = 3'd0;
  localparam diagSelT RD_COUNT_LO = 3'd1;
  localparam diagSelT RD_COUNT_HI = 3'd2;
  localparam diagSelT RD_CONFIG   = 3'd3;
  localparam diagSelT RD_ERRORS   = 3'd4;

endpackage

// ==== hw/diagFuncIf.sv ====
// Decoded diagnostic functions
`timescale 1ns/1ns

interface diagFuncIf;
  import clkPkg::*;

  // Run control strobes
  logic runStart;
  logic runStop;
  logic stepReq;
  logic burstReq;

  // Burst count nibble loads
  logic ldCountLo;
  logic ldCountHi;

  logic clrErrors;
  diagDataT loadData;

  modport ctl (
    output runStart, runStop, stepReq, burstReq,
    output ldCountLo, ldCountHi, clrErrors, loadData
  );

  modport gate (input runStart, runStop, stepReq, burstReq);

  modport count (input ldCountLo, ldCountHi, loadData);

  modport errs (input clrErrors);

endinterface

// ==== hw/diagCtl.sv ====
// Diagnostic function decoder and config registers
`timescale 1ns/1ns

module diagCtl (
  input  logic             CLK,
  input  logic             rstN,
  input  logic             diagStrobe,
  input  logic             diagLoad,
  input  clkPkg::diagSelT  diagSel,
  input  clkPkg::diagDataT diagData,
  diagFuncIf.ctl           fn,
  output clkPkg::rateT     rate,
  output clkPkg::parErrT   checkEn,
  output logic             errStopEn,
  output logic             eboxReset
);
  import clkPkg::*;

  logic ctlStrobe;
  logic ldStrobe;
  logic ldRate;
  logic ldCheckEn;
  logic ldErrStop;
  logic relReset;

  assign ctlStrobe = diagStrobe & ~diagLoad;
  assign ldStrobe  = diagStrobe & diagLoad;

  // One registered strobe per function
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      fn.runStart  <= 1'b0;
      fn.runStop   <= 1'b0;
      fn.stepReq   <= 1'b0;
      fn.burstReq  <= 1'b0;
      fn.clrErrors <= 1'b0;
      relReset     <= 1'b0;
      fn.ldCountLo <= 1'b0;
      fn.ldCountHi <= 1'b0;
      ldRate       <= 1'b0;
      ldCheckEn    <= 1'b0;
      ldErrStop    <= 1'b0;
    end else begin
      fn.runStart  <= ctlStrobe && diagSel == CTL_START;
      fn.stepReq   <= ctlStrobe && diagSel == CTL_STEP;
      fn.burstReq  <= ctlStrobe && diagSel == CTL_BURST;
      fn.clrErrors <= ctlStrobe && diagSel == CTL_SET_RESET;
      relReset     <= ctlStrobe && diagSel == CTL_CLR_RESET;
      // Stop plus the unused codes 3 and 5
      fn.runStop   <= ctlStrobe && !(diagSel inside {CTL_START, CTL_STEP, CTL_BURST,
                                                     CTL_SET_RESET, CTL_CLR_RESET});
      fn.ldCountLo <= ldStrobe && diagSel == LD_COUNT_LO;
      fn.ldCountHi <= ldStrobe && diagSel == LD_COUNT_HI;
      ldRate       <= ldStrobe && diagSel == LD_RATE;
      ldCheckEn    <= ldStrobe && diagSel == LD_CHECK_EN;
      ldErrStop    <= ldStrobe && diagSel == LD_ERR_STOP;
    end
  end

  always_ff @(posedge CLK) begin
    if (diagStrobe) begin
      fn.loadData <= diagData;
    end
  end

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      rate      <= '0;
      checkEn   <= '0;
      errStopEn <= 1'b0;
      eboxReset <= 1'b1;
    end else begin
      if (ldRate) begin
        rate <= fn.loadData[1:0];
      end
      if (ldCheckEn) begin
        checkEn <= fn.loadData[3:1];
      end
      if (ldErrStop) begin
        errStopEn <= fn.loadData[0];
      end
      // Code 6 asserts reset as well as clearing errors
      if (fn.clrErrors) begin
        eboxReset <= 1'b1;
      end else if (relReset) begin
        eboxReset <= 1'b0;
      end
    end
  end

endmodule

// ==== hw/burstCounter.sv ====
// Burst counter
`timescale 1ns/1ns

module burstCounter (
  input  logic               CLK,
  input  logic               rstN,
  diagFuncIf.count           fn,
  input  logic               burstStep,
  output clkPkg::burstCountT count,
  output logic               countZero
);

  assign countZero = (count == '0);

  // Nibble loads win over a decrement in the same cycle
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      count <= '0;
    end else if (fn.ldCountLo) begin
      count[3:0] <= fn.loadData;
    end else if (fn.ldCountHi) begin
      count[7:4] <= fn.loadData;
    end else if (burstStep && !countZero) begin
      count <= count - 8'd1;
    end
  end

endmodule

// ==== hw/clkGate.sv ====
// EBOX clock gate and run state
`timescale 1ns/1ns

module clkGate (
  input  logic         CLK,
  input  logic         rstN,
  diagFuncIf.gate      fn,
  input  clkPkg::rateT rate,
  input  logic         countZero,
  input  logic         errorStop,
  output logic         eboxClk,
  output logic         burstStep,
  output logic         go,
  output logic         bursting,
  output logic         stepPending
);
  import clkPkg::*;

  rateT divCnt;
  logic tick;
  logic clkOk;

  // Free-running divider ticks when the count reaches rate
  assign tick = (divCnt == rate);

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      divCnt <= '0;
    end else if (tick) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 2'd1;
    end
  end

  assign clkOk     = tick & ~errorStop;
  assign burstStep = clkOk & bursting & ~countZero;
  assign eboxClk   = clkOk & (go | stepPending) | burstStep;

  // Each run function reloads all three flags
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      go          <= 1'b0;
      bursting    <= 1'b0;
      stepPending <= 1'b0;
    end else if (fn.runStart || fn.runStop || fn.stepReq || fn.burstReq) begin
      go          <= fn.runStart;
      bursting    <= fn.burstReq;
      stepPending <= fn.stepReq;
    end else begin
      if (bursting && countZero) begin
        bursting <= 1'b0;
      end
      // One strobe then done
      if (stepPending && eboxClk) begin
        stepPending <= 1'b0;
      end
    end
  end

endmodule

// ==== hw/parityErrors.sv ====
// Parity error flags
`timescale 1ns/1ns

module parityErrors (
  input  logic           CLK,
  input  logic           rstN,
  diagFuncIf.errs        fn,
  input  logic           dramParBad,
  input  logic           cramParBad,
  input  logic           fmParBad,
  input  clkPkg::parErrT checkEn,
  input  logic           errStopEn,
  output clkPkg::parErrT errFlags,
  output logic           errorStop
);
  import clkPkg::*;

  parErrT parBad;

  assign parBad = {dramParBad, cramParBad, fmParBad};

  // Sticky until code 6
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      errFlags <= '0;
    end else if (fn.clrErrors) begin
      errFlags <= '0;
    end else begin
      errFlags <= errFlags | (parBad & checkEn);
    end
  end

  assign errorStop = errStopEn & (|errFlags);

endmodule

// ==== hw/diagRead.sv ====
// Diagnostic readback mux
`timescale 1ns/1ns

module diagRead (
  input  clkPkg::diagSelT    readSel,
  input  logic               go,
  input  logic               bursting,
  input  logic               stepPending,
  input  logic               eboxReset,
  input  logic               errorStop,
  input  clkPkg::burstCountT count,
  input  clkPkg::rateT       rate,
  input  clkPkg::parErrT     checkEn,
  input  clkPkg::parErrT     errFlags,
  input  logic               errStopEn,
  output clkPkg::readWordT   readData
);
  import clkPkg::*;

  // Fields listed from the top bit down
  always_comb begin
    case (readSel)
      RD_STATUS: begin
        readData = {go, bursting, stepPending, eboxReset, errorStop, 1'b0};
      end
      RD_COUNT_LO: begin
        readData = count[5:0];
      end
      RD_COUNT_HI: begin
        readData = {3'b000, count[7:6], errStopEn};
      end
      RD_CONFIG: begin
        readData = {checkEn, 1'b0, rate};
      end
      RD_ERRORS: begin
        readData = {errFlags, 3'b000};
      end
      default: begin
        readData = '0;
      end
    endcase
  end

endmodule

// ==== hw/eboxClkCtl.sv ====
// EBOX clock control board
`timescale 1ns/1ns

module eboxClkCtl (
  input  logic             CLK,
  input  logic             rstN,
  input  logic             diagStrobe,
  input  logic             diagLoad,
  input  clkPkg::diagSelT  diagSel,
  input  clkPkg::diagDataT diagData,
  input  clkPkg::diagSelT  readSel,
  input  logic             dramParBad,
  input  logic             cramParBad,
  input  logic             fmParBad,
  output logic             eboxClk,
  output logic             eboxReset,
  output logic             errorStop,
  output clkPkg::readWordT readData
);
  import clkPkg::*;

  rateT       rate;
  parErrT     checkEn;
  logic       errStopEn;
  burstCountT count;
  logic       countZero;
  logic       burstStep;
  parErrT     errFlags;
  logic       go;
  logic       bursting;
  logic       stepPending;

  diagFuncIf fnIf ();

  diagCtl uDiagCtl (
    .CLK(CLK), .rstN(rstN), .diagStrobe(diagStrobe), .diagLoad(diagLoad),
    .diagSel(diagSel), .diagData(diagData), .fn(fnIf.ctl), .rate(rate),
    .checkEn(checkEn), .errStopEn(errStopEn), .eboxReset(eboxReset)
  );

  burstCounter uBurstCounter (
    .CLK(CLK), .rstN(rstN), .fn(fnIf.count), .burstStep(burstStep),
    .count(count), .countZero(countZero)
  );

  clkGate uClkGate (
    .CLK(CLK), .rstN(rstN), .fn(fnIf.gate), .rate(rate), .countZero(countZero),
    .errorStop(errorStop), .eboxClk(eboxClk), .burstStep(burstStep), .go(go),
    .bursting(bursting), .stepPending(stepPending)
  );

  parityErrors uParityErrors (
    .CLK(CLK), .rstN(rstN), .fn(fnIf.errs), .dramParBad(dramParBad),
    .cramParBad(cramParBad), .fmParBad(fmParBad), .checkEn(checkEn),
    .errStopEn(errStopEn), .errFlags(errFlags), .errorStop(errorStop)
  );

  diagRead uDiagRead (
    .readSel(readSel), .go(go), .bursting(bursting), .stepPending(stepPending),
    .eboxReset(eboxReset), .errorStop(errorStop), .count(count), .rate(rate),
    .checkEn(checkEn), .errFlags(errFlags), .errStopEn(errStopEn),
    .readData(readData)
  );

endmodule

// ==== sim/clkGateProperties.sv ====
// Clock gate run state checks
`timescale 1ns/1ns

module clkGateProperties (
  input logic CLK,
  input logic rstN,
  input logic eboxClk,
  input logic errorStop,
  input logic go,
  input logic bursting,
  input logic stepPending
);

  // Error stop blocks every strobe
  noClkInErrStop: assert property (@(posedge CLK) disable iff (!rstN)
      !(eboxClk && errorStop))
    else $error("eboxClk high while errorStop is set");

  noClkWhenIdle: assert property (@(posedge CLK) disable iff (!rstN)
      eboxClk |-> (go || bursting || stepPending))
    else $error("eboxClk high with no run flag set");

  oneRunFlag: assert property (@(posedge CLK) disable iff (!rstN)
      $onehot0({go, bursting, stepPending}))
    else $error("more than one run flag set");

endmodule

bind clkGate clkGateProperties uProps (
  .CLK(CLK), .rstN(rstN), .eboxClk(eboxClk), .errorStop(errorStop),
  .go(go), .bursting(bursting), .stepPending(stepPending)
);

// ==== sim/eboxClkCtlTb.sv ====
// EBOX clock control testbench
`timescale 1ns/1ns

module eboxClkCtlTb;
  import clkPkg::*;

  localparam int PERIOD       = 10;
  localparam int RESET_CYCLES = 8;
  localparam int ROUNDS       = 12;
  // Worst case per round is a 255 count burst at rate 3
  localparam int ROUND_CYCLES = 1300;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + 40 + ROUNDS * ROUND_CYCLES) * 2 * PERIOD;

  logic CLK;
  logic rstN;
  logic diagStrobe;
  logic diagLoad;
  diagSelT diagSel;
  diagDataT diagData;
  diagSelT readSel;
  logic dramParBad;
  logic cramParBad;
  logic fmParBad;
  logic eboxClk;
  logic eboxReset;
  logic errorStop;
  readWordT readData;

  // Reference model state
  logic mPctl, mPld, mGo, mBurst, mStep, mErrStopEn, mReset;
  diagSelT mPsel;
  diagDataT mPdata;
  rateT mRate, mDiv;
  parErrT mCheck, mFlags;
  burstCountT mCount;

  int errors = 0;
  int checks = 0;
  int strobes = 0;
  logic randRead = 1'b1;

  eboxClkCtl UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic logic expErrStop();
    return mErrStopEn && (mFlags != '0);
  endfunction

  function automatic logic expBurstStep();
    return (mDiv == mRate) && !expErrStop() && mBurst && (mCount != '0);
  endfunction

  function automatic logic expClk();
    return ((mDiv == mRate) && !expErrStop() && (mGo || mStep)) || expBurstStep();
  endfunction

  function automatic readWordT expRead(diagSelT sel);
    case (sel)
      RD_STATUS:   return {mGo, mBurst, mStep, mReset, expErrStop(), 1'b0};
      RD_COUNT_LO: return mCount[5:0];
      RD_COUNT_HI: return {3'b000, mCount[7:6], mErrStopEn};
      RD_CONFIG:   return {mCheck, 1'b0, mRate};
      RD_ERRORS:   return {mFlags, 3'b000};
      default:     return '0;
    endcase
  endfunction

  // One board clock from old state to new state
  task automatic advanceModel();
    logic clkNow;
    logic stepNow;
    logic tick;
    clkNow = expClk();
    stepNow = expBurstStep();
    tick = (mDiv == mRate);
    if (mPctl && mPsel < CTL_SET_RESET) begin
      mGo = (mPsel == CTL_START);
      mBurst = (mPsel == CTL_BURST);
      mStep = (mPsel == CTL_STEP);
    end else begin
      mBurst = mBurst && (mCount != '0);
      mStep = mStep && !clkNow;
    end
    if (mPld && mPsel == LD_COUNT_LO) mCount[3:0] = mPdata;
    else if (mPld && mPsel == LD_COUNT_HI) mCount[7:4] = mPdata;
    else if (stepNow) mCount = mCount - 8'd1;
    if (mPctl && mPsel == CTL_SET_RESET) mFlags = '0;
    else mFlags = mFlags | ({dramParBad, cramParBad, fmParBad} & mCheck);
    mDiv = tick ? 2'd0 : mDiv + 2'd1;
    if (mPld && mPsel == LD_RATE) mRate = mPdata[1:0];
    if (mPld && mPsel == LD_CHECK_EN) mCheck = mPdata[3:1];
    if (mPld && mPsel == LD_ERR_STOP) mErrStopEn = mPdata[0];
    if (mPctl && mPsel == CTL_SET_RESET) mReset = 1'b1;
    else if (mPctl && mPsel == CTL_CLR_RESET) mReset = 1'b0;
    // Decode stage
    mPctl = diagStrobe && !diagLoad;
    mPld = diagStrobe && diagLoad;
    mPsel = diagSel;
    if (diagStrobe) mPdata = diagData;
  endtask

  always @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      {mPctl, mPld, mGo, mBurst, mStep, mErrStopEn} = '0;
      {mPsel, mPdata, mRate, mDiv, mCheck, mFlags, mCount} = '0;
      mReset = 1'b1;
    end else begin
      advanceModel();
    end
  end

  task automatic checkVal(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Compare outputs on the falling edge before inputs change
  task automatic nextCycle();
    @(negedge CLK);
    checkVal("eboxClk", 32'(eboxClk), 32'(expClk()));
    checkVal("eboxReset", 32'(eboxReset), 32'(mReset));
    checkVal("errorStop", 32'(errorStop), 32'(expErrStop()));
    checkVal("readData", 32'(readData), 32'(expRead(readSel)));
    if (eboxClk) strobes++;
    if (randRead) readSel = diagSelT'($urandom);
  endtask

  task automatic idle(int n);
    repeat (n) nextCycle();
  endtask

  task automatic issue(logic load, diagSelT sel, diagDataT data);
    diagStrobe = 1'b1;
    diagLoad = load;
    diagSel = sel;
    diagData = data;
    nextCycle();
    diagStrobe = 1'b0;
    diagData = diagDataT'($urandom);
  endtask

  task automatic stopClock();
    issue(1'b0, CTL_STOP, 4'h0);
    idle(2);
  endtask

  task automatic waitFlagClear(int bitIdx, int limit, string what);
    int n;
    n = 0;
    randRead = 1'b0;
    readSel = RD_STATUS;
    do begin
      nextCycle();
      n++;
    end while (readData[bitIdx] && n < limit);
    randRead = 1'b1;
    assert (!readData[bitIdx]) else begin
      errors++;
      $display("%s still running after %0d cycles", what, n);
    end
  endtask

  task automatic waitStrobe(int limit, output int gap);
    gap = 0;
    do begin
      nextCycle();
      gap++;
    end while (!eboxClk && gap < limit);
    assert (eboxClk) else begin
      errors++;
      $display("No eboxClk strobe within %0d cycles at %0t ns", limit, $time);
    end
  endtask

  task automatic burstTest(logic zeroCount);
    burstCountT k;
    k = zeroCount ? burstCountT'(0) : burstCountT'($urandom);
    stopClock();
    issue(1'b1, LD_RATE, diagDataT'($urandom));
    issue(1'b1, LD_COUNT_LO, k[3:0]);
    issue(1'b1, LD_COUNT_HI, k[7:4]);
    idle(2);
    strobes = 0;
    issue(1'b0, CTL_BURST, 4'h0);
    idle(1);
    waitFlagClear(4, 1100, "Burst");
    idle(4);
    checkVal("burst strobes", strobes, 32'(k));
    randRead = 1'b0;
    readSel = RD_COUNT_LO;
    nextCycle();
    checkVal("count after burst", 32'(readData), 0);
    readSel = RD_COUNT_HI;
    nextCycle();
    checkVal("count high after burst", 32'(readData[2:1]), 0);
    randRead = 1'b1;
  endtask

  task automatic stepAndStopTest();
    stopClock();
    strobes = 0;
    issue(1'b0, CTL_STEP, 4'h0);
    idle(1);
    waitFlagClear(3, 20, "Single step");
    idle(4);
    checkVal("single step strobes", strobes, 1);
    issue(1'b0, CTL_START, 4'h0);
    idle(2 + $urandom % 12);
    issue(1'b0, CTL_STOP, 4'h0);
    nextCycle();
    strobes = 0;
    idle(12);
    checkVal("strobes after stop", strobes, 0);
  endtask

  task automatic rateTest();
    rateT r;
    int gap;
    r = rateT'($urandom);
    stopClock();
    issue(1'b1, LD_RATE, {2'b00, r});
    idle(2);
    issue(1'b0, CTL_START, 4'h0);
    waitStrobe(8, gap);
    repeat (4) begin
      waitStrobe(8, gap);
      checkVal("strobe spacing", gap, 32'(r) + 1);
    end
    stopClock();
  endtask

  task automatic parityTest();
    parErrT en;
    int gap;
    en = parErrT'($urandom);
    if (en == '0) en = 3'b100;
    issue(1'b1, LD_CHECK_EN, {en, 1'b0});
    issue(1'b1, LD_ERR_STOP, 4'h1);
    issue(1'b0, CTL_START, 4'h0);
    idle(2);
    repeat (16) begin
      {dramParBad, cramParBad, fmParBad} = parErrT'($urandom) & parErrT'($urandom);
      nextCycle();
    end
    // Make sure at least one enabled flag gets set
    {dramParBad, cramParBad, fmParBad} = en;
    nextCycle();
    {dramParBad, cramParBad, fmParBad} = 3'b000;
    idle(1);
    checkVal("errorStop", 32'(errorStop), 1);
    strobes = 0;
    idle(10);
    checkVal("strobes in error stop", strobes, 0);
    issue(1'b0, CTL_SET_RESET, 4'h0);
    issue(1'b0, CTL_CLR_RESET, 4'h0);
    issue(1'b0, CTL_START, 4'h0);
    waitStrobe(12, gap);
    stopClock();
    issue(1'b1, LD_ERR_STOP, 4'h0);
  endtask

  initial begin
    void'($urandom(21));
    rstN = 1'b0;
    diagStrobe = 1'b0;
    diagLoad = 1'b0;
    diagSel = '0;
    diagData = '0;
    readSel = RD_STATUS;
    {dramParBad, cramParBad, fmParBad} = 3'b000;
    idle(RESET_CYCLES);
    rstN = 1'b1;
    // Reset layout of every select
    randRead = 1'b0;
    for (int s = 0; s < 8; s++) begin
      readSel = diagSelT'(s);
      nextCycle();
    end
    randRead = 1'b1;
    checkVal("eboxReset after reset", 32'(eboxReset), 1);
    issue(1'b0, CTL_CLR_RESET, 4'h0);
    idle(2);
    checkVal("eboxReset after release", 32'(eboxReset), 0);
    for (int round = 0; round < ROUNDS; round++) begin
      repeat (6) issue(1'b1, diagSelT'($urandom), diagDataT'($urandom));
      idle(2);
      // First round bursts a zero count
      burstTest(round == 0);
      stepAndStopTest();
      rateTest();
      parityTest();
    end
    idle(4);
    $display("Run finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
hw/clkPkg.sv
hw/diagFuncIf.sv
hw/diagCtl.sv
hw/burstCounter.sv
hw/clkGate.sv
hw/parityErrors.sv
hw/diagRead.sv
hw/eboxClkCtl.sv
sim/clkGateProperties.sv
sim/eboxClkCtlTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= eboxClkCtlTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
